//--- flist.f
verilog/jtag_pkg.sv
verilog/bitq_fsm.sv
verilog/ctrlport_to_jtag.sv
verilog/ctrlport_resp_combine.sv
verilog/jtag_subsystem.sv
verif/jtag_target_model.sv
verif/tb_jtag_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the jtag subsystem testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_jtag_subsystem -f flist.f

sim_out=$(./obj_dir/Vtb_jtag_subsystem)
echo "$sim_out"

if echo "$sim_out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

//--- verif/jtag_cases.txt
# name op addr data status, addr and data in hex, data is the expected read data
# ops W write, R read, P poll until ready, B back-to-back read, N no ack, T tck rises on chain addr
rst_ctl0 R 00008 80000001 okay
rst_ctl1 R 00048 80000001 okay
rst_rx0 R 0000C 00000000 okay
xfer_tx W 00000 000000A5 okay
xfer_stb W 00004 00000081 okay
xfer_go W 00008 00000702 okay
xfer_poll P 00008 80000702 okay
xfer_rx R 0000C 0000004A okay
xfer_tck0 T 00000 00000008 okay
xfer_tck1 T 00001 00000000 okay
busy_tx W 00000 0000000C okay
busy_stb W 00004 00000000 okay
busy_go W 00008 000003C8 okay
busy_txwr W 00000 00000003 cmderr
busy_ctlwr W 00008 00000701 cmderr
busy_poll P 00008 800003C8 okay
busy_rx R 0000C 00000009 okay
busy_tck0 T 00000 0000000C okay
srst_go W 00008 000004C8 okay
srst_wr W 00008 80000000 okay
srst_ctl R 00008 800004C8 okay
srst_tck0 T 00000 0000000C okay
bad_rd R 00010 00000000 cmderr
bad_wr W 00014 00000000 cmderr
bad_rd1 R 00050 00000000 cmderr
unmapped N 00080 00000000 none
ilv_tx1 W 00040 12345678 okay
ilv_stb1 W 00044 00000000 okay
ilv_go1 W 00048 00000F03 okay
ilv_tx0 W 00000 0000003C okay
ilv_go0 W 00008 00000701 okay
ilv_poll1 P 00048 80000F03 okay
ilv_poll0 P 00008 80000701 okay
b2b_rx0 B 0000C 00000079 okay
b2b_rx1 B 0004C 0000ACF0 okay
b2b_ctl0 B 00008 80000701 okay
b2b_ctl1 B 00048 80000F03 okay
ilv_tck0 T 00000 00000014 okay
ilv_tck1 T 00001 00000010 okay

//--- verif/jtag_target_model.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_target_model
  import jtag_pkg::*;
(
  input  jtag_pins_t  pins,
  output logic        tdo,
  output logic [31:0] rise_count
);

  // one bit echo register, kept across transfers
  logic        echo_q = 1'b0;
  logic [31:0] rises  = '0;

  // previous tdi shows up on tdo
  assign tdo        = echo_q;
  assign rise_count = rises;

  // load on every rising tck
  always @(posedge pins.tck) begin
    echo_q <= pins.tdi;
    rises  <= rises + 1;
  end

endmodule

`default_nettype wire

//--- verif/tb_jtag_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_subsystem
  import jtag_pkg::*;
();

  localparam int          half_period  = 50;
  localparam int          reset_cycles = 8;
  localparam int unsigned seed         = 32'h130b3cbd;
  // longest transfer, 32 bits at prescaler 255
  localparam int          max_xfer     = 32 * 2 * 256;
  localparam int          max_cases    = 64;
  localparam int          max_polls    = 4096;
  localparam logic [addr_w-1:0] chain1_base = 20'h00040;

  logic           ctrlport_clk;
  logic           ctrlport_rst;
  ctrlport_req_t  req;
  ctrlport_resp_t resp;
  jtag_pins_t     chain0_pins;
  jtag_pins_t     chain1_pins;
  logic           chain0_tdo;
  logic           chain1_tdo;
  logic [31:0]    chain0_rises;
  logic [31:0]    chain1_rises;

  // case table from the data file
  logic [127:0]      case_name [max_cases];
  logic [7:0]        case_op   [max_cases];
  logic [addr_w-1:0] case_addr [max_cases];
  logic [31:0]       case_data [max_cases];
  logic [63:0]       case_sts  [max_cases];
  bit                case_ok   [max_cases];
  int                num_cases;
  bit                cases_loaded;
  int                pass_count;
  int                fail_count;

  // expected pin bits per chain, from the accepted writes
  logic [31:0]       tx_shadow  [2];
  logic [31:0]       stb_shadow [2];
  int                bit_pos    [2];

  // --------------------------------------------------
  // DUT and one echo target per chain
  // --------------------------------------------------
  jtag_subsystem #(
    .chain0_base       (20'h00000),
    .chain1_base       (chain1_base),
    .default_prescaler (8'd1)
  ) uut (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req          (req),
    .resp         (resp),
    .chain0_pins  (chain0_pins),
    .chain0_tdo   (chain0_tdo),
    .chain1_pins  (chain1_pins),
    .chain1_tdo   (chain1_tdo)
  );

  jtag_target_model target0 (.pins(chain0_pins), .tdo(chain0_tdo), .rise_count(chain0_rises));
  jtag_target_model target1 (.pins(chain1_pins), .tdo(chain1_tdo), .rise_count(chain1_rises));

  always #(half_period) ctrlport_clk = ~ctrlport_clk;

  // --------------------------------------------------
  // case file and helpers
  // --------------------------------------------------
  task automatic load_cases();
    int            fd;
    int            rc;
    logic [1023:0] line_buf;
    logic [127:0]  name_txt;
    logic [63:0]   op_txt;
    logic [31:0]   addr_val;
    logic [31:0]   data_val;
    logic [63:0]   sts_txt;
    num_cases = 0;
    fd = $fopen("verif/jtag_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/jtag_cases.txt");
      fail_count++;
    end else begin
      while ($fgets(line_buf, fd) != 0) begin
        name_txt = '0;
        op_txt   = '0;
        sts_txt  = '0;
        rc = $sscanf(line_buf, "%s %s %h %h %s", name_txt, op_txt, addr_val, data_val, sts_txt);
        // blank lines and # comments skipped
        if (rc >= 1 && name_txt != "#") begin
          if (rc != 5 || num_cases >= max_cases) begin
            $display("malformed case line: %0s", line_buf);
            fail_count++;
          end else begin
            case_name[num_cases] = name_txt;
            case_op[num_cases]   = op_txt[7:0];
            case_addr[num_cases] = addr_val[addr_w-1:0];
            case_data[num_cases] = data_val;
            case_sts[num_cases]  = sts_txt;
            case_ok[num_cases]   = 1'b1;
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
    cases_loaded = 1'b1;
  endtask

  function automatic ctrl_status_e status_of(input logic [63:0] txt);
    if (txt == "cmderr") return sts_cmderr;
    if (txt == "tserr") return sts_tserr;
    if (txt == "slverr") return sts_slverr;
    return sts_okay;
  endfunction

  // W is a write, every other op reads
  function automatic ctrlport_req_t req_for(input int idx);
    ctrlport_req_t r;
    r      = '0;
    r.wr   = (case_op[idx] == "W");
    r.rd   = !r.wr;
    r.addr = case_addr[idx];
    if (r.wr) begin
      r.data = case_data[idx];
    end
    return r;
  endfunction

  // follow accepted writes so the pin checks know what each chain shifts
  task automatic track_write(input int idx);
    int         ch;
    logic [4:0] off;
    ch  = (case_addr[idx] >= chain1_base) ? 1 : 0;
    off = case_addr[idx][4:0];
    if (case_op[idx] == "W" && status_of(case_sts[idx]) == sts_okay) begin
      if (off == 5'h00) begin
        tx_shadow[ch] = case_data[idx];
      end else if (off == 5'h04) begin
        stb_shadow[ch] = case_data[idx];
      end else if (off == 5'h08 && !case_data[idx][31]) begin
        // new transfer starts from bit 0
        bit_pos[ch] = 0;
      end
    end
  endtask

  // tdi and tms must carry the expected bit at every rising tck
  task automatic compare_pins(input int ch, input jtag_pins_t p);
    if (bit_pos[ch] >= 32) begin
      $display("tck rose on chain %0d with no transfer started", ch);
      fail_count++;
    end else begin
      if (p.tdi !== tx_shadow[ch][bit_pos[ch]]) begin
        $display("Fail chain%0d_tdi bit %0d expected %0b actual %0b", ch, bit_pos[ch],
                 tx_shadow[ch][bit_pos[ch]], p.tdi);
        fail_count++;
      end
      if (p.tms !== stb_shadow[ch][bit_pos[ch]]) begin
        $display("Fail chain%0d_tms bit %0d expected %0b actual %0b", ch, bit_pos[ch],
                 stb_shadow[ch][bit_pos[ch]], p.tms);
        fail_count++;
      end
      bit_pos[ch]++;
    end
  endtask

  always @(posedge chain0_pins.tck) compare_pins(0, chain0_pins);
  always @(posedge chain1_pins.tck) compare_pins(1, chain1_pins);

  task automatic check_resp(input int idx, input ctrlport_resp_t got);
    logic [31:0] exp_data;
    // write responses carry zero data
    exp_data = (case_op[idx] == "W") ? 32'h0 : case_data[idx];
    if (!got.ack) begin
      $display("%0s: no ack two cycles after the strobe", case_name[idx]);
      case_ok[idx] = 1'b0;
    end else begin
      if (got.status != status_of(case_sts[idx])) begin
        $display("Fail %0s status expected %0d actual %0d", case_name[idx],
                 status_of(case_sts[idx]), got.status);
        case_ok[idx] = 1'b0;
      end
      if (got.data !== exp_data) begin
        $display("Fail %0s data expected %08h actual %08h", case_name[idx], exp_data, got.data);
        case_ok[idx] = 1'b0;
      end
    end
  endtask

  // strobes on consecutive edges, each ack due two edges later
  task automatic run_burst(input int first, input int count);
    int c;
    for (c = 0; c < count + 2; c++) begin
      @(posedge ctrlport_clk);
      if (c < count) begin
        req <= req_for(first + c);
        track_write(first + c);
      end else begin
        req <= '0;
      end
      @(negedge ctrlport_clk);
      if (c >= 2) begin
        check_resp(first + c - 2, resp);
      end else if (resp.ack) begin
        $display("%0s: ack arrived before the second clock edge", case_name[first]);
        case_ok[first] = 1'b0;
      end
    end
  endtask

  task automatic single_read(input logic [addr_w-1:0] addr, output ctrlport_resp_t got);
    ctrlport_req_t rd_req;
    int            c;
    rd_req      = '0;
    rd_req.rd   = 1'b1;
    rd_req.addr = addr;
    got         = '0;
    for (c = 0; c < 3; c++) begin
      @(posedge ctrlport_clk);
      if (c == 0) begin
        req <= rd_req;
      end else begin
        req <= '0;
      end
      @(negedge ctrlport_clk);
      if (c == 2) begin
        got = resp;
      end
    end
  endtask

  // reread CONTROL until ready, then check the last read
  task automatic poll_ready(input int idx);
    ctrlport_resp_t got;
    int             tries;
    tries = 0;
    do begin
      single_read(case_addr[idx], got);
      tries++;
    end while (got.ack && !got.data[ready_bit] && tries < max_polls);
    if (!got.ack) begin
      $display("%0s: no ack while polling for ready", case_name[idx]);
      case_ok[idx] = 1'b0;
    end else if (!got.data[ready_bit]) begin
      $display("%0s: ready stayed low after %0d polls", case_name[idx], tries);
      case_ok[idx] = 1'b0;
    end else begin
      check_resp(idx, got);
    end
  endtask

  // unmapped address, bus must stay quiet
  task automatic expect_silence(input int idx);
    int c;
    for (c = 0; c < 5; c++) begin
      @(posedge ctrlport_clk);
      if (c == 0) begin
        req <= req_for(idx);
      end else begin
        req <= '0;
      end
      @(negedge ctrlport_clk);
      if (resp.ack) begin
        $display("%0s: unexpected ack for an unmapped address", case_name[idx]);
        case_ok[idx] = 1'b0;
      end
    end
  endtask

  task automatic check_rises(input int idx);
    logic [31:0] seen;
    @(negedge ctrlport_clk);
    seen = (case_addr[idx] == '0) ? chain0_rises : chain1_rises;
    if (seen != case_data[idx]) begin
      $display("Fail %0s tck rises expected %0d actual %0d", case_name[idx],
               case_data[idx], seen);
      case_ok[idx] = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int idx;
    int burst;
    int j;
    void'($urandom(seed));
    ctrlport_clk = 1'b0;
    ctrlport_rst = 1'b1;
    req          = '0;
    pass_count   = 0;
    fail_count   = 0;
    // no transfer expected on either chain yet
    for (j = 0; j < 2; j++) begin
      tx_shadow[j]  = '0;
      stb_shadow[j] = '0;
      bit_pos[j]    = 32;
    end
    load_cases();
    repeat (reset_cycles) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;
    idx = 0;
    while (idx < num_cases) begin
      // idle gap of 0 to 3 cycles
      repeat ($urandom % 4) @(posedge ctrlport_clk);
      burst = 1;
      case (case_op[idx])
        "W", "R": run_burst(idx, 1);
        "B": begin
          while (idx + burst < num_cases && case_op[idx + burst] == "B") begin
            burst++;
          end
          run_burst(idx, burst);
        end
        "P": poll_ready(idx);
        "N": expect_silence(idx);
        "T": check_rises(idx);
        default: begin
          $display("%0s: unknown op in the case file", case_name[idx]);
          case_ok[idx] = 1'b0;
        end
      endcase
      for (j = 0; j < burst; j++) begin
        if (case_ok[idx + j]) begin
          pass_count++;
          $display("ok     %0s", case_name[idx + j]);
        end else begin
          fail_count++;
          $display("failed %0s", case_name[idx + j]);
        end
      end
      idx += burst;
    end
    $display("cases passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog, one longest transfer per case line
  initial begin
    int unsigned limit;
    wait (cases_loaded);
    limit = reset_cycles + (num_cases + 1) * max_xfer;
    repeat (limit) @(posedge ctrlport_clk);
    $display("timeout after %0d cycles, the run did not finish", limit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bitq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module bitq_fsm
  import jtag_pkg::*;
(
  input  logic                   ctrlport_clk,
  input  logic                   ctrlport_rst,
  input  logic [prescaler_w-1:0] prescaler,
  input  logic [length_w-1:0]    len,
  input  logic                   start,
  input  logic [data_w-1:0]      wr_data,
  input  logic [data_w-1:0]      stb_data,
  input  logic                   tdo,
  output jtag_pins_t             pins,
  output logic                   ready,
  output logic [data_w-1:0]      rd_data
);

  // --------------------------------------------------
  // state and counters
  // --------------------------------------------------
  bitq_state_e            state;
  // cycles left in the current tck phase
  logic [prescaler_w-1:0] half_cnt;
  // bit being shifted, lsb first
  logic [length_w-1:0]    bit_idx;
  logic [length_w-1:0]    next_idx;

  // idx never wraps, last bit ends the transfer
  assign next_idx = bit_idx + 1'b1;

  // ready straight from state
  assign ready = (state == st_idle);

  // --------------------------------------------------
  // shift engine
  // --------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state    <= st_idle;
      half_cnt <= '0;
      bit_idx  <= '0;
      pins     <= '0;
      rd_data  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_low;
            half_cnt  <= prescaler;
            bit_idx   <= '0;
            // first bit out with tck low
            pins.tck  <= 1'b0;
            pins.tdi  <= wr_data[0];
            pins.tms  <= stb_data[0];
            // old capture gone, bits above len stay zero
            rd_data   <= '0;
          end
        end

        st_low: begin
          if (half_cnt == '0) begin
            state            <= st_high;
            half_cnt         <= prescaler;
            pins.tck         <= 1'b1;
            // target still drives its previous bit here
            rd_data[bit_idx] <= tdo;
          end else begin
            half_cnt <= half_cnt - 1'b1;
          end
        end

        st_high: begin
          if (half_cnt == '0) begin
            pins.tck <= 1'b0;
            if (bit_idx == len) begin
              // transfer done, park the pins low
              state    <= st_idle;
              pins.tdi <= 1'b0;
              pins.tms <= 1'b0;
            end else begin
              // next bit, set up on the falling edge
              state    <= st_low;
              half_cnt <= prescaler;
              bit_idx  <= next_idx;
              pins.tdi <= wr_data[next_idx];
              pins.tms <= stb_data[next_idx];
            end
          end else begin
            half_cnt <= half_cnt - 1'b1;
          end
        end

        default: begin
          state <= st_idle;
          pins  <= '0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // slave must hold off start until the engine is back
  a_start_when_ready: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
      start |-> ready
  ) else $error("bitq_fsm: start while busy");

  // tck parked low whenever the engine is idle
  a_tck_low_idle: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
      (state == st_idle) |-> !pins.tck
  ) else $error("bitq_fsm: tck high in idle");

endmodule

`default_nettype wire

//--- verilog/ctrlport_resp_combine.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlport_resp_combine
  import jtag_pkg::*;
(
  input  logic           ctrlport_clk,
  input  logic           ctrlport_rst,
  input  ctrlport_resp_t resp_a,
  input  ctrlport_resp_t resp_b,
  output ctrlport_resp_t resp
);

  // --------------------------------------------------
  // response merge
  // --------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp <= resp_idle;
    end else if (resp_a.ack) begin
      resp <= resp_a;
    end else if (resp_b.ack) begin
      resp <= resp_b;
    end else begin
      // nobody answered, keep the bus clean
      resp <= resp_idle;
    end
  end

  // two acks means the address windows overlap
  a_single_ack: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
      !(resp_a.ack && resp_b.ack)
  ) else $error("ctrlport_resp_combine: both slaves acked");

endmodule

`default_nettype wire

//--- verilog/ctrlport_to_jtag.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlport_to_jtag
  import jtag_pkg::*;
#(
  parameter logic [addr_w-1:0]      base_address      = 20'h00000,
  parameter logic [prescaler_w-1:0] default_prescaler = 8'd1
) (
  input  logic           ctrlport_clk,
  input  logic           ctrlport_rst,
  input  ctrlport_req_t  req,
  output ctrlport_resp_t resp,
  output jtag_pins_t     pins,
  input  logic           tdo
);

  // --------------------------------------------------
  // local registers
  // --------------------------------------------------
  logic [data_w-1:0]      tx_data_reg;
  logic [data_w-1:0]      stb_data_reg;
  logic [prescaler_w-1:0] prescaler_reg;
  logic [length_w-1:0]    length_reg;
  // self clearing strobes
  logic                   start_reg;
  logic                   soft_rst_stb;

  // engine side
  logic                   bitq_rst;
  logic                   bitq_ready;
  logic [data_w-1:0]      rx_data;
  logic                   engine_ready;

  // decode
  logic [addr_w-1:0]      offset;
  logic                   in_window;
  logic                   soft_rst_req;
  logic [data_w-1:0]      control_rd;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  assign offset    = req.addr - base_address;
  // offset form avoids overflow at the top of the map
  assign in_window = (req.addr >= base_address) && (offset < num_addresses);

  // soft reset bypasses the ready check
  assign soft_rst_req = in_window && (offset == reg_control) && req.data[reset_bit];

  // a start still in flight counts as busy
  assign engine_ready = bitq_ready && !start_reg;

  // CONTROL readback
  always_comb begin
    control_rd                                  = '0;
    control_rd[prescaler_lsb +: prescaler_w]    = prescaler_reg;
    control_rd[length_lsb +: length_w]          = length_reg;
    control_rd[ready_bit]                       = engine_ready;
  end

  // --------------------------------------------------
  // register access
  // --------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      tx_data_reg   <= '0;
      stb_data_reg  <= '0;
      prescaler_reg <= default_prescaler;
      length_reg    <= '0;
      start_reg     <= 1'b0;
      soft_rst_stb  <= 1'b0;
      resp          <= resp_idle;
    end else begin
      // one cycle pulses by default
      start_reg    <= 1'b0;
      soft_rst_stb <= 1'b0;
      resp         <= resp_idle;

      if (req.wr && in_window) begin
        // writes answer with zero data
        resp.ack <= 1'b1;
        if (soft_rst_req) begin
          // prescaler and length kept
          soft_rst_stb <= 1'b1;
        end else if (!engine_ready) begin
          // engine inputs must stay stable
          resp.status <= sts_cmderr;
        end else begin
          case (offset)
            reg_tx_data: begin
              tx_data_reg <= req.data;
            end
            reg_stb_data: begin
              stb_data_reg <= req.data;
            end
            reg_control: begin
              prescaler_reg <= req.data[prescaler_lsb +: prescaler_w];
              length_reg    <= req.data[length_lsb +: length_w];
              start_reg     <= 1'b1;
            end
            default: begin
              resp.status <= sts_cmderr;
            end
          endcase
        end
      end else if (req.rd && in_window) begin
        resp.ack <= 1'b1;
        case (offset)
          reg_control: begin
            resp.data <= control_rd;
          end
          reg_rx_data: begin
            resp.data <= rx_data;
          end
          // tx and stb are write only, data stays zero
          default: begin
            resp.status <= sts_cmderr;
          end
        endcase
      end
    end
  end

  // --------------------------------------------------
  // shift engine
  // --------------------------------------------------

  // global or soft reset
  assign bitq_rst = ctrlport_rst | soft_rst_stb;

  bitq_fsm jtag_master (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (bitq_rst),
    .prescaler    (prescaler_reg),
    .len          (length_reg),
    .start        (start_reg),
    .wr_data      (tx_data_reg),
    .stb_data     (stb_data_reg),
    .tdo          (tdo),
    .pins         (pins),
    .ready        (bitq_ready),
    .rd_data      (rx_data)
  );

  // master never issues both strobes at once
  a_one_strobe: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
      !(req.wr && req.rd)
  ) else $error("ctrlport_to_jtag: wr and rd together");

endmodule

`default_nettype wire

//--- verilog/jtag_pkg.sv
`default_nettype none

package jtag_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int addr_w = 20;
  localparam int data_w = 32;

  // controlport status codes
  typedef enum logic [1:0] {
    sts_okay   = 2'b00,
    sts_cmderr = 2'b01,
    sts_tserr  = 2'b10,
    sts_slverr = 2'b11
  } ctrl_status_e;

  // one request from the bus master
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } ctrlport_req_t;

  // one response back to the master
  typedef struct packed {
    logic              ack;
    ctrl_status_e      status;
    logic [data_w-1:0] data;
  } ctrlport_resp_t;

  // idle response, nothing on the bus
  localparam ctrlport_resp_t resp_idle = '{ack: 1'b0, status: sts_okay, data: '0};

  // master driven pins of one chain
  typedef struct packed {
    logic tck;
    logic tdi;
    logic tms;
  } jtag_pins_t;

  // --------------------------------------------------
  // register map, offsets within one window
  // --------------------------------------------------
  localparam logic [addr_w-1:0] reg_tx_data   = 20'h00000;
  localparam logic [addr_w-1:0] reg_stb_data  = 20'h00004;
  localparam logic [addr_w-1:0] reg_control   = 20'h00008;
  localparam logic [addr_w-1:0] reg_rx_data   = 20'h0000C;
  localparam logic [addr_w-1:0] num_addresses = 20'd32;

  // CONTROL fields
  localparam int prescaler_lsb = 0;
  localparam int prescaler_w   = 8;
  localparam int length_lsb    = 8;
  localparam int length_w      = 5;
  // bit 31 is reset on write, ready on read
  localparam int reset_bit     = 31;
  localparam int ready_bit     = 31;

  // bit queue engine states
  typedef enum logic [1:0] {
    st_idle = 2'b00,
    st_low  = 2'b01,
    st_high = 2'b10
  } bitq_state_e;

endpackage

`default_nettype wire

//--- verilog/jtag_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_subsystem
  import jtag_pkg::*;
#(
  parameter logic [addr_w-1:0]      chain0_base       = 20'h00000,
  parameter logic [addr_w-1:0]      chain1_base       = 20'h00040,
  parameter logic [prescaler_w-1:0] default_prescaler = 8'd1
) (
  input  logic           ctrlport_clk,
  input  logic           ctrlport_rst,
  input  ctrlport_req_t  req,
  output ctrlport_resp_t resp,
  output jtag_pins_t     chain0_pins,
  input  logic           chain0_tdo,
  output jtag_pins_t     chain1_pins,
  input  logic           chain1_tdo
);

  // per chain responses into the combiner
  ctrlport_resp_t chain0_resp;
  ctrlport_resp_t chain1_resp;

  // --------------------------------------------------
  // chain controllers, same request to both
  // --------------------------------------------------
  ctrlport_to_jtag #(
    .base_address      (chain0_base),
    .default_prescaler (default_prescaler)
  ) chain0 (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req          (req),
    .resp         (chain0_resp),
    .pins         (chain0_pins),
    .tdo          (chain0_tdo)
  );

  ctrlport_to_jtag #(
    .base_address      (chain1_base),
    .default_prescaler (default_prescaler)
  ) chain1 (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req          (req),
    .resp         (chain1_resp),
    .pins         (chain1_pins),
    .tdo          (chain1_tdo)
  );

  // --------------------------------------------------
  // one response back to the master
  // --------------------------------------------------
  ctrlport_resp_combine resp_merge (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .resp_a       (chain0_resp),
    .resp_b       (chain1_resp),
    .resp         (resp)
  );

endmodule

`default_nettype wire
